/* src/rope_map_pkg.sv */
`default_nettype none

package rope_map_pkg;

    // one flag per client, used for both request and done codes
    // bit 2 player 2, bit 1 player 1, bit 0 draw
    typedef logic [2:0] req_code_t;

    // bit positions inside req_code_t
    localparam int unsigned client_draw    = 0;
    localparam int unsigned client_player1 = 1;
    localparam int unsigned client_player2 = 2;

    // map geometry defaults, 16 rows of 32 bits
    localparam int unsigned default_addr_width = 4;
    localparam int unsigned default_data_width = 32;

endpackage

`default_nettype wire

/* src/map_ram.sv */
`timescale 1ns/1ps
`default_nettype none

// single-port map memory, stands in for the block ram of the game
module map_ram #(
    parameter int ADDR_WIDTH = rope_map_pkg::default_addr_width,
    parameter int DATA_WIDTH = rope_map_pkg::default_data_width
) (
    input  wire                   clock,
    input  wire  [ADDR_WIDTH-1:0] address,
    input  wire                   write_enable,
    input  wire  [DATA_WIDTH-1:0] write_data,
    output logic [DATA_WIDTH-1:0] read_data
);

    localparam int ROW_COUNT = 1 << ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] rows [ROW_COUNT];  // map contents, no initial value

    always_ff @(posedge clock) begin
        if (write_enable) begin
            rows[address] <= write_data;
        end
        read_data <= rows[address];  // read-first, old row on a write cycle
    end

endmodule

`default_nettype wire

/* src/map_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

// fixed-priority access controller for the shared map memory
// priority from high to low is draw read, p1 write, p2 write, p1 read, p2 read
module map_arbiter #(
    parameter int ADDR_WIDTH = rope_map_pkg::default_addr_width,
    parameter int DATA_WIDTH = rope_map_pkg::default_data_width
) (
    input  wire                          clock,
    input  wire                          resetn,
    input  wire  rope_map_pkg::req_code_t read_req,
    input  wire  [1:0]                   write_req,      // bit 0 player 1, bit 1 player 2
    input  wire  [ADDR_WIDTH-1:0]        draw_address,
    input  wire  [ADDR_WIDTH-1:0]        player1_index,
    input  wire  [ADDR_WIDTH-1:0]        player2_index,
    input  wire  [DATA_WIDTH-1:0]        player1_write_data,
    input  wire  [DATA_WIDTH-1:0]        player2_write_data,
    output rope_map_pkg::req_code_t      read_done,
    output rope_map_pkg::req_code_t      write_done,
    output logic [ADDR_WIDTH-1:0]        ram_address,
    output logic                         ram_write_enable,
    output logic [DATA_WIDTH-1:0]        ram_write_data
);

    import rope_map_pkg::*;

    typedef enum logic [1:0] {
        st_select,   // sample requests and latch the winner
        st_access,   // memory does the access
        st_report,   // read data is out and done rises
        st_recover   // done is high while clients drop their request
    } state_t;

    state_t state;

    req_code_t grant_read;   // client served by the access in flight
    req_code_t grant_write;

    req_code_t             pick_read;
    req_code_t             pick_write;
    logic [ADDR_WIDTH-1:0] pick_address;
    logic [DATA_WIDTH-1:0] pick_data;
    logic                  pick_any;

    // priority pick that is only taken in select
    always_comb begin
        pick_read    = '0;
        pick_write   = '0;
        pick_address = draw_address;
        pick_data    = player1_write_data;
        if (read_req[client_draw]) begin
            pick_read[client_draw] = 1'b1;
        end else if (write_req[0]) begin
            pick_write[client_player1] = 1'b1;
            pick_address               = player1_index;
        end else if (write_req[1]) begin
            pick_write[client_player2] = 1'b1;
            pick_address               = player2_index;
            pick_data                  = player2_write_data;
        end else if (read_req[client_player1]) begin
            pick_read[client_player1] = 1'b1;
            pick_address              = player1_index;
        end else if (read_req[client_player2]) begin
            pick_read[client_player2] = 1'b1;
            pick_address              = player2_index;
        end
    end

    assign pick_any = |{pick_read, pick_write};

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state            <= st_recover;
            grant_read       <= '0;
            grant_write      <= '0;
            ram_write_enable <= 1'b0;
            read_done        <= '0;
            write_done       <= '0;
        end else begin
            read_done  <= '0;  // done is a single-cycle pulse
            write_done <= '0;
            case (state)
                st_select: begin
                    if (pick_any) begin
                        grant_read       <= pick_read;
                        grant_write      <= pick_write;
                        ram_write_enable <= |pick_write;
                        state            <= st_access;
                    end
                end
                st_access: begin
                    ram_write_enable <= 1'b0;  // write lands on this edge
                    state            <= st_report;
                end
                st_report: begin
                    read_done  <= grant_read;
                    write_done <= grant_write;
                    state      <= st_recover;
                end
                default: begin
                    state <= st_select;
                end
            endcase
        end
    end

    // address and data hold until the next grant so read_data stays put
    always_ff @(posedge clock) begin
        if (state == st_select && pick_any) begin
            ram_address    <= pick_address;
            ram_write_data <= pick_data;
        end
    end

    // only one client is told it was served per cycle
    assert property (@(posedge clock) disable iff (!resetn)
        $onehot0({read_done, write_done}))
        else $error("map_arbiter: more than one done bit high");

    // a write strobe only follows a player write request that no draw read outranked
    assert property (@(posedge clock) disable iff (!resetn)
        ram_write_enable |-> (state == st_access) && (grant_write != '0)
            && $past((write_req != '0) && !read_req[client_draw]))
        else $error("map_arbiter: write enable without a write grant");

endmodule

`default_nettype wire

/* src/map_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

// draw client, sweeps the map rows in order for the display
module map_scanner #(
    parameter int ADDR_WIDTH = rope_map_pkg::default_addr_width,
    parameter int DATA_WIDTH = rope_map_pkg::default_data_width
) (
    input  wire                   clock,
    input  wire                   resetn,
    input  wire                   scan_enable,
    input  wire                   draw_done,
    input  wire  [DATA_WIDTH-1:0] read_data,
    output logic                  draw_req,
    output logic [ADDR_WIDTH-1:0] draw_address,
    output logic                  row_valid,
    output logic [ADDR_WIDTH-1:0] row_index,
    output logic [DATA_WIDTH-1:0] row_bits
);

    localparam int ROW_COUNT = 1 << ADDR_WIDTH;
    localparam logic [ADDR_WIDTH-1:0] LAST_ROW = ADDR_WIDTH'(ROW_COUNT - 1);

    logic [ADDR_WIDTH-1:0] row;         // row being requested
    logic [ADDR_WIDTH-1:0] last_index;  // last reported row, held between pulses
    logic [DATA_WIDTH-1:0] last_bits;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            row      <= '0;
            draw_req <= 1'b0;
        end else if (draw_req) begin
            if (draw_done) begin
                draw_req <= 1'b0;  // one idle cycle lets a player in
                if (!scan_enable || row == LAST_ROW) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end
        end else if (scan_enable) begin
            draw_req <= 1'b1;
        end else begin
            row <= '0;  // stopped, next sweep starts at the top
        end
    end

    always_ff @(posedge clock) begin
        if (draw_done) begin
            last_index <= row;
            last_bits  <= read_data;
        end
    end

    assign draw_address = row;

    // row is reported in the done cycle itself, then held
    assign row_valid = draw_done;
    assign row_index = draw_done ? row : last_index;
    assign row_bits  = draw_done ? read_data : last_bits;

    // the arbiter may only answer a request that is still up
    assert property (@(posedge clock) disable iff (!resetn)
        draw_done |-> draw_req)
        else $error("map_scanner: draw done without a draw request");

endmodule

`default_nettype wire

/* src/rope_map_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rope_map_top #(
    parameter int ADDR_WIDTH = rope_map_pkg::default_addr_width,
    parameter int DATA_WIDTH = rope_map_pkg::default_data_width
) (
    input  wire                   clock,
    input  wire                   resetn,
    input  wire                   scan_enable,
    input  wire                   player1_read_req,
    input  wire                   player1_write_req,
    input  wire  [ADDR_WIDTH-1:0] player1_index,
    input  wire  [DATA_WIDTH-1:0] player1_write_data,
    input  wire                   player2_read_req,
    input  wire                   player2_write_req,
    input  wire  [ADDR_WIDTH-1:0] player2_index,
    input  wire  [DATA_WIDTH-1:0] player2_write_data,
    output logic                  player1_read_done,
    output logic                  player1_write_done,
    output logic                  player2_read_done,
    output logic                  player2_write_done,
    output logic [DATA_WIDTH-1:0] read_data,
    output logic                  row_valid,
    output logic [ADDR_WIDTH-1:0] row_index,
    output logic [DATA_WIDTH-1:0] row_bits
);

    import rope_map_pkg::*;

    req_code_t             read_req;
    logic [1:0]            write_req;
    req_code_t             read_done;
    req_code_t             write_done;   // draw bit never set
    logic                  draw_req;
    logic [ADDR_WIDTH-1:0] draw_address;
    logic [ADDR_WIDTH-1:0] ram_address;
    logic                  ram_write_enable;
    logic [DATA_WIDTH-1:0] ram_write_data;

    assign read_req[client_draw]    = draw_req;
    assign read_req[client_player1] = player1_read_req;
    assign read_req[client_player2] = player2_read_req;
    assign write_req                = {player2_write_req, player1_write_req};

    assign player1_read_done  = read_done[client_player1];
    assign player2_read_done  = read_done[client_player2];
    assign player1_write_done = write_done[client_player1];
    assign player2_write_done = write_done[client_player2];

    map_scanner #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) map_scanner_inst (
        .clock       (clock),
        .resetn      (resetn),
        .scan_enable (scan_enable),
        .draw_done   (read_done[client_draw]),
        .read_data   (read_data),
        .draw_req    (draw_req),
        .draw_address(draw_address),
        .row_valid   (row_valid),
        .row_index   (row_index),
        .row_bits    (row_bits)
    );

    map_arbiter #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) map_arbiter_inst (
        .clock             (clock),
        .resetn            (resetn),
        .read_req          (read_req),
        .write_req         (write_req),
        .draw_address      (draw_address),
        .player1_index     (player1_index),
        .player2_index     (player2_index),
        .player1_write_data(player1_write_data),
        .player2_write_data(player2_write_data),
        .read_done         (read_done),
        .write_done        (write_done),
        .ram_address       (ram_address),
        .ram_write_enable  (ram_write_enable),
        .ram_write_data    (ram_write_data)
    );

    map_ram #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) map_ram_inst (
        .clock       (clock),
        .address     (ram_address),
        .write_enable(ram_write_enable),
        .write_data  (ram_write_data),
        .read_data   (read_data)
    );

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// free-running clock with a synchronous reset pulse at the start
module clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clock,
    output logic resetn
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2.0) clock = ~clock;
    end

    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        resetn = 1'b1;  // released away from the sampling edge
    end

endmodule

`default_nettype wire

/* bench/rope_map_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rope_map_tb;

    import rope_map_pkg::*;

    localparam int ADDR_WIDTH = default_addr_width;
    localparam int DATA_WIDTH = default_data_width;
    localparam int ROW_COUNT  = 1 << ADDR_WIDTH;
    localparam int WAIT_LIMIT = 40;  // cycles before a wait gives up

    logic                  clock;
    logic                  resetn;
    logic                  scan_enable;
    logic                  player1_read_req;
    logic                  player1_write_req;
    logic [ADDR_WIDTH-1:0] player1_index;
    logic [DATA_WIDTH-1:0] player1_write_data;
    logic                  player2_read_req;
    logic                  player2_write_req;
    logic [ADDR_WIDTH-1:0] player2_index;
    logic [DATA_WIDTH-1:0] player2_write_data;
    logic                  player1_read_done;
    logic                  player1_write_done;
    logic                  player2_read_done;
    logic                  player2_write_done;
    logic [DATA_WIDTH-1:0] read_data;
    logic                  row_valid;
    logic [ADDR_WIDTH-1:0] row_index;
    logic [DATA_WIDTH-1:0] row_bits;

    logic [DATA_WIDTH-1:0] model [ROW_COUNT];  // expected map that follows each write done
    int unsigned           seed;

    clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(3)) clock_gen_inst (
        .clock (clock),
        .resetn(resetn)
    );

    rope_map_top #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) rope_map_top_inst (
        .clock(clock), .resetn(resetn), .scan_enable(scan_enable),
        .player1_read_req(player1_read_req), .player1_write_req(player1_write_req),
        .player1_index(player1_index), .player1_write_data(player1_write_data),
        .player2_read_req(player2_read_req), .player2_write_req(player2_write_req),
        .player2_index(player2_index), .player2_write_data(player2_write_data),
        .player1_read_done(player1_read_done), .player1_write_done(player1_write_done),
        .player2_read_done(player2_read_done), .player2_write_done(player2_write_done),
        .read_data(read_data), .row_valid(row_valid), .row_index(row_index),
        .row_bits(row_bits)
    );

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_row(input string name, input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] expected);
        if (got !== expected) begin
            $display("error at %0t: %s = %h, expected %h", $time, name, got, expected);
            stop_run();
        end
    endtask

    task automatic check_index(input string name, input logic [ADDR_WIDTH-1:0] got,
                               input logic [ADDR_WIDTH-1:0] expected);
        if (got !== expected) begin
            $display("error at %0t: %s = %0d, expected %0d", $time, name, got, expected);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("error at %0t: %s = %b, expected %b", $time, name, got, expected);
            stop_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s did not arrive within %0d cycles", $time, what, WAIT_LIMIT);
        stop_run();
    endtask

    function automatic logic [DATA_WIDTH-1:0] random_row();
        return DATA_WIDTH'($urandom());
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] random_index();
        return ADDR_WIDTH'($urandom_range(ROW_COUNT - 1, 0));
    endfunction

    task automatic drive_write(input int player, input logic level,
                               input logic [ADDR_WIDTH-1:0] index,
                               input logic [DATA_WIDTH-1:0] data);
        if (player == 1) begin
            player1_write_req  = level;
            player1_index      = index;
            player1_write_data = data;
        end else begin
            player2_write_req  = level;
            player2_index      = index;
            player2_write_data = data;
        end
    endtask

    task automatic drive_read(input int player, input logic level,
                              input logic [ADDR_WIDTH-1:0] index);
        if (player == 1) begin
            player1_read_req = level;
            player1_index    = index;
        end else begin
            player2_read_req = level;
            player2_index    = index;
        end
    endtask

    // waits for the player's done pulse and drops the request in that cycle
    task automatic player_write(input int player, input logic [ADDR_WIDTH-1:0] index,
                                input logic [DATA_WIDTH-1:0] data);
        int cycles;
        cycles = 0;
        @(negedge clock);
        drive_write(player, 1'b1, index, data);
        while ((player == 1 ? player1_write_done : player2_write_done) !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                report_timeout($sformatf("player%0d_write_done", player));
            end
            @(negedge clock);
            cycles++;
        end
        drive_write(player, 1'b0, index, data);
        model[index] = data;
        @(negedge clock);
        check_bit($sformatf("player%0d_write_done", player),
                  player == 1 ? player1_write_done : player2_write_done, 1'b0);
    endtask

    task automatic player_read(input int player, input logic [ADDR_WIDTH-1:0] index);
        int cycles;
        cycles = 0;
        @(negedge clock);
        drive_read(player, 1'b1, index);
        while ((player == 1 ? player1_read_done : player2_read_done) !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                report_timeout($sformatf("player%0d_read_done", player));
            end
            @(negedge clock);
            cycles++;
        end
        check_row("read_data", read_data, model[index]);
        drive_read(player, 1'b0, index);
        @(negedge clock);
        check_bit($sformatf("player%0d_read_done", player),
                  player == 1 ? player1_read_done : player2_read_done, 1'b0);
    endtask

    // no done pulse at all so a dropped request is not served twice
    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            check_bit("player1_read_done", player1_read_done, 1'b0);
            check_bit("player1_write_done", player1_write_done, 1'b0);
            check_bit("player2_read_done", player2_read_done, 1'b0);
            check_bit("player2_write_done", player2_write_done, 1'b0);
            check_bit("row_valid", row_valid, 1'b0);
        end
    endtask

    task automatic wait_row_pulse();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (row_valid !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                report_timeout("row_valid");
            end
            @(negedge clock);
            cycles++;
        end
    endtask

    // both players hit the same row in one cycle and the higher priority one must finish first
    task automatic race_same_row(input logic second_is_read);
        logic [ADDR_WIDTH-1:0] index;
        logic [DATA_WIDTH-1:0] data1;
        logic [DATA_WIDTH-1:0] data2;
        int                    cycles;
        int                    first_at;
        int                    second_at;
        index     = random_index();
        data1     = random_row();
        data2     = ~data1;  // always differs from data1
        cycles    = 0;
        first_at  = -1;
        second_at = -1;
        @(negedge clock);
        if (second_is_read) begin
            drive_write(2, 1'b1, index, data1);
            drive_read(1, 1'b1, index);
        end else begin
            drive_write(1, 1'b1, index, data1);
            drive_write(2, 1'b1, index, data2);
        end
        while (first_at < 0 || second_at < 0) begin
            if (cycles == WAIT_LIMIT) begin
                report_timeout("the second done pulse of a same-row race");
            end
            @(negedge clock);
            cycles++;
            if (!second_is_read && player1_write_done === 1'b1) begin
                first_at     = cycles;
                model[index] = data1;
                drive_write(1, 1'b0, index, data1);
            end
            if (player2_write_done === 1'b1) begin
                if (second_is_read) begin
                    first_at     = cycles;
                    model[index] = data1;
                    drive_write(2, 1'b0, index, data1);
                end else begin
                    second_at    = cycles;
                    model[index] = data2;
                    drive_write(2, 1'b0, index, data2);
                end
            end
            if (second_is_read && player1_read_done === 1'b1) begin
                second_at = cycles;
                check_row("read_data", read_data, data1);
                drive_read(1, 1'b0, index);
            end
        end
        if (second_at <= first_at) begin
            $display("the lower-priority request on row %0d finished first", index);
            stop_run();
        end
        if (!second_is_read) begin
            player_read(1, index);  // model now holds player 2's value
        end
    endtask

    initial begin
        logic [ADDR_WIDTH-1:0] rows [8];
        logic [ADDR_WIDTH-1:0] index;
        logic [ADDR_WIDTH-1:0] expected;
        int                    cycles;

        scan_enable        = 1'b0;
        player1_read_req   = 1'b0;
        player1_write_req  = 1'b0;
        player1_index      = '0;
        player1_write_data = '0;
        player2_read_req   = 1'b0;
        player2_write_req  = 1'b0;
        player2_index      = '0;
        player2_write_data = '0;
        seed               = 32'hb56c_a8b5;
        void'($urandom(seed));

        cycles = 0;
        while (resetn !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                report_timeout("reset release");
            end
            @(posedge clock);
            cycles++;
        end

        expect_idle(8);

        for (int i = 0; i < 8; i++) begin
            rows[i] = random_index();
            player_write(1, rows[i], random_row());
            expect_idle(4);
        end
        for (int i = 0; i < 8; i++) begin
            player_read(1, rows[i]);
            expect_idle(4);
        end

        for (int i = 0; i < 4; i++) begin
            index = random_index();
            player_write(1, index, random_row());
            player_read(2, index);
        end
        for (int i = 0; i < 4; i++) begin
            index = random_index();
            player_write(2, index, random_row());
            player_read(1, index);
        end

        race_same_row(1'b0);  // player 1 write against player 2 write
        race_same_row(1'b1);  // player 2 write against player 1 read

        for (int r = 0; r < ROW_COUNT; r++) begin
            player_write(1, ADDR_WIDTH'(r), random_row());
        end
        @(negedge clock);
        scan_enable = 1'b1;
        expected    = '0;
        for (int n = 0; n <= ROW_COUNT; n++) begin  // full sweep plus the wrap to row 0
            wait_row_pulse();
            check_index("row_index", row_index, expected);
            check_row("row_bits", row_bits, model[expected]);
            expected = expected + 1'b1;
        end
        index = random_index();
        player_write(2, index, random_row());
        player_read(1, index);
        @(negedge clock);
        scan_enable = 1'b0;
        repeat (12) @(negedge clock);  // row in flight drains
        expect_idle(8);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* rope_map_top.f */
src/rope_map_pkg.sv
src/map_ram.sv
src/map_arbiter.sv
src/map_scanner.sv
src/rope_map_top.sv
bench/clock_gen.sv
bench/rope_map_tb.sv

/* Bender.yml */
package:
  name: rope_map

sources:
  - files:
      - src/rope_map_pkg.sv
      - src/map_ram.sv
      - src/map_arbiter.sv
      - src/map_scanner.sv
      - src/rope_map_top.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/rope_map_tb.sv
